// ==== common/vme_pkg.sv ====
package vme_pkg;

	// ******************************
	// register map
	// ******************************

	// register addressed by the latched VME address
	typedef enum logic [3:0] {
		SEL_NONE,
		SEL_STATUS,
		SEL_TMODE,
		SEL_TCKEN,
		SEL_FREEZE,
		SEL_HITMASK,
		SEL_START_RD,
		SEL_EDRO,
		SEL_HIT_LOOP,
		SEL_STAT1,
		SEL_STAT2,
		SEL_TIMER,
		SEL_BITMAP,
		SEL_VERSION
	} reg_sel_e;

	// external user data access, the only AM code we answer
	localparam logic [5:0] AM_DATA_ACCESS = 6'b001001;

	// byte offsets inside the slot window
	localparam logic [23:0] OFF_STATUS   = 24'h000000;
	localparam logic [23:0] OFF_TMODE    = 24'h000008;
	localparam logic [23:0] OFF_TCKEN    = 24'h00000C;
	localparam logic [23:0] OFF_FREEZE   = 24'h000028;
	localparam logic [23:0] OFF_HITMASK  = 24'h00003C;
	localparam logic [23:0] OFF_START_RD = 24'h000050;
	localparam logic [23:0] OFF_EDRO     = 24'h000060;
	localparam logic [23:0] OFF_HIT_LOOP = 24'h000070;
	localparam logic [23:0] OFF_STAT1    = 24'h000080;
	localparam logic [23:0] OFF_STAT2    = 24'h000090;
	localparam logic [23:0] OFF_TIMER    = 24'h0000A0;
	localparam logic [23:0] OFF_BITMAP   = 24'h0000D0;
	localparam logic [23:0] OFF_VERSION  = 24'h008000;

	// day 5 bits, month, year and version 4 bits each
	localparam logic [16:0] FW_VERSION = {5'd14, 4'd7, 4'd11, 4'd1};

	// ******************************
	// bundled register state
	// ******************************

	// field order matches the top level control outputs
	typedef struct packed {
		logic        tmode;
		logic        en_tck;
		logic        freeze;
		logic        edro_mode;
		logic        start_rd_fifo;
		logic        hit_loop;
		logic        bitmap_en;
		logic [17:0] hitmask;
	} ctrl_t;

	// overflow flag sits in bit 31 of every word
	typedef struct packed {
		logic [31:0] stat1;
		logic [31:0] stat2;
		logic [31:0] timer;
	} stat_t;

endpackage

// ==== design/addr_decode.sv ====
module addr_decode #(
	parameter int SLOT_BITS = 5
) (
	input  logic                  clk,
	input  logic                  vme_cycle_end,
	input  logic                  as_,
	input  logic                  ds0_,
	input  logic                  ds1_,
	input  logic                  lword_,
	input  logic                  iack_,
	input  logic                  write_,
	input  logic [5:0]            am,
	input  logic [SLOT_BITS-1:0]  geadd,
	input  logic [31:1]           vadd,
	input  logic                  dtack,
	output vme_pkg::reg_sel_e     sel,
	output logic                  slot_ok,
	output logic                  bad_addr,
	output logic                  cycle_req,
	output logic [31-SLOT_BITS:2] ivadd
);
	logic              am_ok;
	logic              iack_q;
	logic              strb_low;
	logic              reserved;
	logic              read_only;
	logic [23:0]       offset;
	vme_pkg::reg_sel_e dec;

	// ******************************
	// address phase latches
	// ******************************

	// transparent while as_ is high, frozen once the master drops it
	always_latch
	begin
		if (as_)
		begin
			ivadd   <= vadd[31-SLOT_BITS:2];
			slot_ok <= (~geadd == vadd[31:32-SLOT_BITS]);
			am_ok   <= (am == vme_pkg::AM_DATA_ACCESS);
			iack_q  <= iack_;
		end
	end

	// strobes brought into the clock domain
	// forced back to released as soon as the cycle ends
	always_ff @(posedge clk or posedge vme_cycle_end)
	begin
		if (vme_cycle_end)
			strb_low <= 1'b0;
		else
			strb_low <= ~(as_ | ds0_ | ds1_ | lword_);
	end

	// ******************************
	// register decode
	// ******************************

	assign offset   = {ivadd[23:2], 2'b00};
	// bits between the slot field and the 24-bit window must be zero
	assign reserved = (ivadd[31-SLOT_BITS:24] != '0);
	assign bad_addr = slot_ok & reserved;

	always_comb
	begin
		case (offset)
			vme_pkg::OFF_STATUS:   dec = vme_pkg::SEL_STATUS;
			vme_pkg::OFF_TMODE:    dec = vme_pkg::SEL_TMODE;
			vme_pkg::OFF_TCKEN:    dec = vme_pkg::SEL_TCKEN;
			vme_pkg::OFF_FREEZE:   dec = vme_pkg::SEL_FREEZE;
			vme_pkg::OFF_HITMASK:  dec = vme_pkg::SEL_HITMASK;
			vme_pkg::OFF_START_RD: dec = vme_pkg::SEL_START_RD;
			vme_pkg::OFF_EDRO:     dec = vme_pkg::SEL_EDRO;
			vme_pkg::OFF_HIT_LOOP: dec = vme_pkg::SEL_HIT_LOOP;
			vme_pkg::OFF_STAT1:    dec = vme_pkg::SEL_STAT1;
			vme_pkg::OFF_STAT2:    dec = vme_pkg::SEL_STAT2;
			vme_pkg::OFF_TIMER:    dec = vme_pkg::SEL_TIMER;
			vme_pkg::OFF_BITMAP:   dec = vme_pkg::SEL_BITMAP;
			vme_pkg::OFF_VERSION:  dec = vme_pkg::SEL_VERSION;
			default:               dec = vme_pkg::SEL_NONE;
		endcase
	end

	// status, statistics and version have no write side
	assign read_only = dec inside {vme_pkg::SEL_STATUS, vme_pkg::SEL_STAT1,
		vme_pkg::SEL_STAT2, vme_pkg::SEL_TIMER, vme_pkg::SEL_VERSION};

	assign sel = (!slot_ok || reserved || (read_only && !write_)) ? vme_pkg::SEL_NONE : dec;

	// held until dtack comes back, then drops so the chain drains
	assign cycle_req = strb_low & iack_q & slot_ok & am_ok & ~dtack;

endmodule

// ==== design/ctrl_regs.sv ====
module ctrl_regs (
	input  logic              clk,
	// board init, active low
	input  logic              back_init,
	input  logic              wr_strobe,
	input  logic              write_,
	input  vme_pkg::reg_sel_e sel,
	input  logic [31:0]       vmedata,
	output vme_pkg::ctrl_t    ctrl
);
	logic wr_en;

	// write_ still low when the strobe lands
	assign wr_en = wr_strobe & ~write_;

	// ******************************
	// control registers
	// ******************************

	// single bit registers take data bit 0
	// hitmask keeps its value through init and must be loaded after power up
	always_ff @(posedge clk)
	begin
		if (!back_init)
		begin
			ctrl.tmode         <= 1'b0;
			ctrl.en_tck        <= 1'b0;
			ctrl.freeze        <= 1'b0;
			ctrl.edro_mode     <= 1'b0;
			ctrl.start_rd_fifo <= 1'b0;
			ctrl.hit_loop      <= 1'b0;
			ctrl.bitmap_en     <= 1'b0;
		end
		else if (wr_en)
		begin
			case (sel)
				vme_pkg::SEL_TMODE:    ctrl.tmode         <= vmedata[0];
				vme_pkg::SEL_TCKEN:    ctrl.en_tck        <= vmedata[0];
				vme_pkg::SEL_FREEZE:   ctrl.freeze        <= vmedata[0];
				vme_pkg::SEL_EDRO:     ctrl.edro_mode     <= vmedata[0];
				vme_pkg::SEL_START_RD: ctrl.start_rd_fifo <= vmedata[0];
				vme_pkg::SEL_HIT_LOOP: ctrl.hit_loop      <= vmedata[0];
				vme_pkg::SEL_BITMAP:   ctrl.bitmap_en     <= vmedata[0];
				vme_pkg::SEL_HITMASK:  ctrl.hitmask       <= vmedata[17:0];
				default:               ;
			endcase
		end
	end

endmodule

// ==== design/dtack_seq.sv ====
module dtack_seq #(
	// at least 5, the capture pulse taps the fifth stage
	parameter int ACK_DEPTH = 7
) (
	input  logic clk,
	input  logic vme_cycle_end,
	input  logic cycle_req,
	input  logic bad_addr,
	input  logic write_,
	output logic dtack,
	output logic dtack_,
	output logic berr_,
	output logic wr_strobe,
	output logic rd_capture
);
	// one bit per clock since the request was seen
	logic [ACK_DEPTH-1:0] chain;

	always_ff @(posedge clk or posedge vme_cycle_end)
	begin
		if (vme_cycle_end)
			chain <= '0;
		else
			chain <= {chain[ACK_DEPTH-2:0], cycle_req};
	end

	// bus error one edge after a request to a reserved address
	always_ff @(posedge clk or posedge vme_cycle_end)
	begin
		if (vme_cycle_end)
			berr_ <= 1'b1;
		else if (chain[0] && bad_addr)
			berr_ <= 1'b0;
	end

	// acknowledge at the end of the chain
	// stays set until the strobes are released
	always_ff @(posedge clk or posedge vme_cycle_end)
	begin
		if (vme_cycle_end)
			dtack <= 1'b0;
		else if (chain[ACK_DEPTH-1] && berr_)
			dtack <= 1'b1;
	end

	assign dtack_ = ~dtack;

	// ******************************
	// single cycle pulses
	// ******************************

	// write lands on edge 3, read select is captured on edge 5
	always_ff @(posedge clk or posedge vme_cycle_end)
	begin
		if (vme_cycle_end)
		begin
			wr_strobe  <= 1'b0;
			rd_capture <= 1'b0;
		end
		else
		begin
			wr_strobe  <= chain[1] & ~chain[2] & ~write_ & berr_;
			rd_capture <= chain[3] & ~chain[4];
		end
	end

endmodule

// ==== design/read_arbiter.sv ====
module read_arbiter (
	input  logic              clk,
	input  logic              vme_cycle_end,
	input  logic              rd_capture,
	input  logic              write_,
	input  vme_pkg::reg_sel_e sel,
	input  vme_pkg::ctrl_t    ctrl,
	input  vme_pkg::stat_t    stat,
	input  logic              err_flag,
	input  logic              err_critical,
	output vme_pkg::reg_sel_e rd_sel,
	output logic              rd_vme,
	output logic [31:0]       ivdata
);
	logic [31:0] ctrl_word, stat_word, fixed_word;

	// read select held for the rest of the cycle
	always_ff @(posedge clk or posedge vme_cycle_end)
	begin
		if (vme_cycle_end)
			rd_sel <= vme_pkg::SEL_NONE;
		else if (rd_capture && write_)
			rd_sel <= sel;
	end

	assign rd_vme = (rd_sel != vme_pkg::SEL_NONE);

	// ******************************
	// bus sources
	// ******************************

	// each source drives zeros unless it holds the grant
	always_comb
	begin
		case (rd_sel)
			vme_pkg::SEL_TMODE:    ctrl_word = {31'b0, ctrl.tmode};
			vme_pkg::SEL_TCKEN:    ctrl_word = {31'b0, ctrl.en_tck};
			vme_pkg::SEL_FREEZE:   ctrl_word = {31'b0, ctrl.freeze};
			vme_pkg::SEL_EDRO:     ctrl_word = {31'b0, ctrl.edro_mode};
			vme_pkg::SEL_START_RD: ctrl_word = {31'b0, ctrl.start_rd_fifo};
			vme_pkg::SEL_HIT_LOOP: ctrl_word = {31'b0, ctrl.hit_loop};
			vme_pkg::SEL_BITMAP:   ctrl_word = {31'b0, ctrl.bitmap_en};
			vme_pkg::SEL_HITMASK:  ctrl_word = {14'b0, ctrl.hitmask};
			default:               ctrl_word = '0;
		endcase
	end

	always_comb
	begin
		case (rd_sel)
			vme_pkg::SEL_STAT1: stat_word = stat.stat1;
			vme_pkg::SEL_STAT2: stat_word = stat.stat2;
			vme_pkg::SEL_TIMER: stat_word = stat.timer;
			default:            stat_word = '0;
		endcase
	end

	// status word and firmware version
	always_comb
	begin
		case (rd_sel)
			vme_pkg::SEL_STATUS:  fixed_word = {30'b0, err_critical, err_flag};
			vme_pkg::SEL_VERSION: fixed_word = {15'b0, vme_pkg::FW_VERSION};
			default:              fixed_word = '0;
		endcase
	end

	assign ivdata = ctrl_word | stat_word | fixed_word;

endmodule

// ==== design/stat_counters.sv ====
module stat_counters #(
	parameter int CNT_WIDTH = 32
) (
	input  logic                 clk,
	input  logic                 back_init,
	input  logic                 vme_cycle_end,
	input  vme_pkg::reg_sel_e    rd_sel,
	input  logic [CNT_WIDTH-1:0] count_patt,
	input  logic [CNT_WIDTH-1:0] count_event,
	output vme_pkg::stat_t       stat,
	output logic                 init_stat_count
);
	logic [CNT_WIDTH-1:0] count_clk;
	logic                 stat1_rd_q;
	logic                 timer_rd_q;
	logic                 rearm;
	logic                 snap_en;
	logic [30:0]          clk_snap, patt_snap, event_snap;
	logic                 ovf_clk, ovf_patt, ovf_event;

	// counter restart on the first cycle of a STAT1 read
	always_ff @(posedge clk or posedge vme_cycle_end)
	begin
		if (vme_cycle_end)
			stat1_rd_q <= 1'b0;
		else
			stat1_rd_q <= (rd_sel == vme_pkg::SEL_STAT1);
	end

	assign init_stat_count = (rd_sel == vme_pkg::SEL_STAT1) & ~stat1_rd_q;

	// remembers a timer read across the release of the strobes
	always_ff @(posedge clk)
	begin
		if (!back_init)
			timer_rd_q <= 1'b0;
		else
			timer_rd_q <= (rd_sel == vme_pkg::SEL_TIMER);
	end

	assign rearm = timer_rd_q & vme_cycle_end;

	// ******************************
	// snapshot control
	// ******************************

	always_ff @(posedge clk)
	begin
		if (!back_init || rearm)
			snap_en <= 1'b1;
		else if (rd_sel == vme_pkg::SEL_STAT1)
			snap_en <= 1'b0;
	end

	// free running clock timer
	always_ff @(posedge clk)
	begin
		if (!back_init || init_stat_count)
			count_clk <= '0;
		else
			count_clk <= count_clk + CNT_WIDTH'(1);
	end

	always_ff @(posedge clk)
	begin
		if (!back_init)
		begin
			clk_snap   <= '0;
			patt_snap  <= '0;
			event_snap <= '0;
		end
		else if (snap_en)
		begin
			clk_snap   <= 31'(count_clk);
			patt_snap  <= 31'(count_patt);
			event_snap <= 31'(count_event);
		end
	end

	// sticky until the next re-arm, independent of the freeze
	always_ff @(posedge clk)
	begin
		if (!back_init || rearm)
		begin
			ovf_clk   <= 1'b0;
			ovf_patt  <= 1'b0;
			ovf_event <= 1'b0;
		end
		else
		begin
			ovf_clk   <= ovf_clk | count_clk[CNT_WIDTH-1];
			ovf_patt  <= ovf_patt | count_patt[CNT_WIDTH-1];
			ovf_event <= ovf_event | count_event[CNT_WIDTH-1];
		end
	end

	// stat1, stat2, timer from the top bit down
	assign stat = {ovf_patt, patt_snap, ovf_event, event_snap, ovf_clk, clk_snap};

endmodule

// ==== design/vme_slave_top.sv ====
module vme_slave_top #(
	parameter int SLOT_BITS = 5,
	parameter int CNT_WIDTH = 32,
	parameter int ACK_DEPTH = 7
) (
	input  logic                  clk,
	// both data strobes released
	input  logic                  vme_cycle_end,
	input  logic                  as_, ds0_, ds1_, iack_, lword_, write_,
	input  logic [5:0]            am,
	input  logic [31:1]           vadd,
	input  logic [31:0]           vmedata,
	// backplane slot address, active low
	input  logic [SLOT_BITS-1:0]  geadd,
	input  logic                  back_init,
	input  logic                  err_flag, err_critical,
	input  logic [CNT_WIDTH-1:0]  count_patt, count_event,
	output logic                  dtack_, berr_,
	output logic                  rd_vme,
	output logic [31:0]           ivdata,
	output logic [31-SLOT_BITS:2] ivadd,
	output logic                  tmode, en_tck, freeze, edro_mode,
	output logic                  start_rd_fifo, hit_loop, bitmap_en,
	output logic [17:0]           hitmask,
	output logic                  init_stat_count
);
	vme_pkg::reg_sel_e sel;
	vme_pkg::reg_sel_e rd_sel;
	vme_pkg::ctrl_t    ctrl;
	vme_pkg::stat_t    stat;
	logic              slot_ok, bad_addr, cycle_req;
	logic              dtack, wr_strobe, rd_capture;

	addr_decode #(.SLOT_BITS(SLOT_BITS)) u_addr_decode (
		.clk(clk), .vme_cycle_end(vme_cycle_end), .as_(as_), .ds0_(ds0_), .ds1_(ds1_),
		.lword_(lword_), .iack_(iack_), .write_(write_), .am(am), .geadd(geadd),
		.vadd(vadd), .dtack(dtack), .sel(sel), .slot_ok(slot_ok), .bad_addr(bad_addr),
		.cycle_req(cycle_req), .ivadd(ivadd));

	dtack_seq #(.ACK_DEPTH(ACK_DEPTH)) u_dtack_seq (
		.clk(clk), .vme_cycle_end(vme_cycle_end), .cycle_req(cycle_req),
		.bad_addr(bad_addr), .write_(write_), .dtack(dtack), .dtack_(dtack_),
		.berr_(berr_), .wr_strobe(wr_strobe), .rd_capture(rd_capture));

	ctrl_regs u_ctrl_regs (
		.clk(clk), .back_init(back_init), .wr_strobe(wr_strobe), .write_(write_),
		.sel(sel), .vmedata(vmedata), .ctrl(ctrl));

	stat_counters #(.CNT_WIDTH(CNT_WIDTH)) u_stat_counters (
		.clk(clk), .back_init(back_init), .vme_cycle_end(vme_cycle_end),
		.rd_sel(rd_sel), .count_patt(count_patt), .count_event(count_event),
		.stat(stat), .init_stat_count(init_stat_count));

	read_arbiter u_read_arbiter (
		.clk(clk), .vme_cycle_end(vme_cycle_end), .rd_capture(rd_capture),
		.write_(write_), .sel(sel), .ctrl(ctrl), .stat(stat), .err_flag(err_flag),
		.err_critical(err_critical), .rd_sel(rd_sel), .rd_vme(rd_vme), .ivdata(ivdata));

	// control register fields out to the board
	assign {tmode, en_tck, freeze, edro_mode, start_rd_fifo, hit_loop, bitmap_en,
		hitmask} = ctrl;

endmodule

// ==== list.f ====
common/vme_pkg.sv
design/addr_decode.sv
design/dtack_seq.sv
design/ctrl_regs.sv
design/stat_counters.sv
design/read_arbiter.sv
design/vme_slave_top.sv
tests/vme_assert.sv
tests/tb_vme.sv

// ==== run.sh ====
#!/bin/sh
# build and run the VME slave testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_vme -f list.f -o sim_vme &&
{
	out=$(./obj_dir/sim_vme)
	printf '%s\n' "$out"
	printf '%s\n' "$out" | grep -qx '>>> PASS'
} &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== tests/tb_vme.sv ====
module tb_vme;
	timeunit 1ns;
	timeprecision 1ps;

	logic        clk, vme_cycle_end, as_, ds0_, ds1_, iack_, lword_, write_;
	logic [5:0]  am;
	logic [31:1] vadd;
	logic [31:0] vmedata, count_patt, count_event, ivdata, rdata, b_patt, b_event, c_event;
	logic [4:0]  geadd;
	logic        back_init, err_flag, err_critical, dtack_, berr_, rd_vme;
	logic        tmode, en_tck, freeze, edro_mode, start_rd_fifo, hit_loop, bitmap_en;
	logic [17:0] hitmask;
	logic [26:2] ivadd;
	logic        init_stat_count, acked, berr_seen, valid, reported;
	integer      seed, init_pulses;
	logic [23:0] bit_regs [7];
	logic [6:0]  exp_bits;

	// board sits in slot 5, geadd lines are inverted
	localparam logic [4:0] SLOT = 5'd5;

	vme_slave_top #(.SLOT_BITS(5), .CNT_WIDTH(32), .ACK_DEPTH(7)) dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// counter restarts seen by the board
	always @(negedge clk)
		if (init_stat_count)
			init_pulses = init_pulses + 1;

	// 60 bus cycles of at most 20 clocks each
	initial
	begin
		#(60 * 20 * 40);
		$display("timeout, the bus cycles did not complete in time");
		reported = 1'b1;
		$display(">>> FAIL");
		$fatal(1, "watchdog expired");
	end

	final
		if (!reported)
			$display(">>> FAIL");

	// ******************************
	// checks and bus cycles
	// ******************************

	task automatic stop_run(input string msg);
		$display("%s", msg);
		reported = 1'b1;
		$display(">>> FAIL");
		$fatal(1, "check failed");
	endtask

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
			stop_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	// full address, slot on top and reserved bits 26:24 as given
	function automatic logic [31:0] addr_of(input logic [4:0] slot, input logic [2:0] rsv,
		input logic [23:0] off);
		return {slot, rsv, off};
	endfunction

	// control bit outputs, tmode on top
	function automatic logic [31:0] ctrl_outputs();
		return {25'b0, tmode, en_tck, freeze, edro_mode, start_rd_fifo, hit_loop, bitmap_en};
	endfunction

	task automatic bus_cycle(input logic [31:0] addr, input logic is_wr, input logic [31:0] wd);
		int n;
		@(negedge clk);
		vadd = addr[31:1];
		write_ = ~is_wr;
		vmedata = wd;
		@(negedge clk);
		as_ = 1'b0;
		lword_ = 1'b0;
		@(negedge clk);
		ds0_ = 1'b0;
		ds1_ = 1'b0;
		n = 0;
		// master waits for an answer, bounded for an unanswered slot
		while (dtack_ && berr_ && n < 20)
		begin
			@(negedge clk);
			n = n + 1;
		end
		acked = !dtack_;
		berr_seen = !berr_;
		rdata = ivdata;
		valid = rd_vme;
		check_eq("ivadd", {7'b0, addr[26:2]}, {7'b0, ivadd});
		// strobes held one more clock
		// after a bus error held past the end of the acknowledge chain
		repeat (berr_seen ? 8 : 1) @(negedge clk);
		// strobes released, cycle end held over two edges
		as_ = 1'b1;
		ds0_ = 1'b1;
		ds1_ = 1'b1;
		lword_ = 1'b1;
		vme_cycle_end = 1'b1;
		repeat (2) @(negedge clk);
		vme_cycle_end = 1'b0;
	endtask

	task automatic write_reg(input string name, input logic [23:0] off, input logic [31:0] wd);
		bus_cycle(addr_of(SLOT, 3'b000, off), 1'b1, wd);
		if (!acked)
			stop_run({"no acknowledge on write of ", name});
	endtask

	task automatic read_reg(input string name, input logic [23:0] off, input logic [31:0] exp);
		bus_cycle(addr_of(SLOT, 3'b000, off), 1'b0, 32'h0);
		if (!acked)
			stop_run({"no acknowledge on read of ", name});
		check_eq({name, " rd_vme"}, 32'h1, {31'b0, valid});
		check_eq(name, exp, rdata);
	endtask

	// ******************************
	// stimulus
	// ******************************

	initial
	begin
		seed = 63897;
		reported = 1'b0;
		init_pulses = 0;
		exp_bits = '0;
		{as_, ds0_, ds1_, iack_, lword_, write_} = 6'b111111;
		am = vme_pkg::AM_DATA_ACCESS;
		vadd = '0;
		vmedata = '0;
		geadd = ~SLOT;
		err_flag = 1'b0;
		err_critical = 1'b0;
		count_patt = '0;
		count_event = '0;
		bit_regs = '{vme_pkg::OFF_TMODE, vme_pkg::OFF_TCKEN, vme_pkg::OFF_FREEZE,
			vme_pkg::OFF_EDRO, vme_pkg::OFF_START_RD, vme_pkg::OFF_HIT_LOOP,
			vme_pkg::OFF_BITMAP};
		vme_cycle_end = 1'b1;
		back_init = 1'b0;
		repeat (10) @(negedge clk);
		vme_cycle_end = 1'b0;
		back_init = 1'b1;

		// control bits and hit mask, written then read back
		write_reg("hitmask", vme_pkg::OFF_HITMASK, 32'h0002_d5a3);
		check_eq("hitmask output", 32'h0002_d5a3, {14'b0, hitmask});
		read_reg("hitmask", vme_pkg::OFF_HITMASK, 32'h0002_d5a3);
		foreach (bit_regs[i])
		begin
			write_reg($sformatf("ctrl bit %0d", i), bit_regs[i], 32'hffff_ffff);
			// one more output bit set after each write
			exp_bits[6 - i] = 1'b1;
			check_eq($sformatf("ctrl outputs after bit %0d", i), {25'b0, exp_bits},
				ctrl_outputs());
			read_reg($sformatf("ctrl bit %0d", i), bit_regs[i], 32'h1);
		end

		// reserved bit set, bus error and no change
		bus_cycle(addr_of(SLOT, 3'b001, vme_pkg::OFF_TMODE), 1'b1, 32'h0);
		if (acked || !berr_seen)
			stop_run("reserved address not answered with a bus error");
		read_reg("tmode after bad write", vme_pkg::OFF_TMODE, 32'h1);
		check_eq("ctrl outputs after bad write", 32'h7f, ctrl_outputs());

		// another slot, no answer at all
		bus_cycle(addr_of(SLOT + 5'd1, 3'b000, vme_pkg::OFF_TMODE), 1'b0, 32'h0);
		if (acked || berr_seen)
			stop_run("slave answered a cycle for another slot");

		// fixed words
		err_flag = 1'b1;
		read_reg("status flag", vme_pkg::OFF_STATUS, 32'h1);
		err_flag = 1'b0;
		err_critical = 1'b1;
		read_reg("status critical", vme_pkg::OFF_STATUS, 32'h2);
		read_reg("version", vme_pkg::OFF_VERSION, {15'b0, vme_pkg::FW_VERSION});

		// timer read re-arms with top bits clear on both counters
		count_patt = $random(seed) & 32'h7fff_ffff;
		count_event = $random(seed) & 32'h7fff_ffff;
		bus_cycle(addr_of(SLOT, 3'b000, vme_pkg::OFF_TIMER), 1'b0, 32'h0);
		if (!acked)
			stop_run("no acknowledge on timer read");
		b_patt = $random(seed) | 32'h8000_0000;
		b_event = $random(seed) & 32'h7fff_ffff;
		c_event = $random(seed);
		count_patt = b_patt;
		count_event = b_event;
		read_reg("stat1", vme_pkg::OFF_STAT1, b_patt);
		// frozen snapshot, overflow still collects
		count_event = c_event;
		read_reg("stat2", vme_pkg::OFF_STAT2, {c_event[31], b_event[30:0]});
		check_eq("init_stat_count pulses", 32'd1, init_pulses);

		// board init clears every control bit
		@(negedge clk);
		back_init = 1'b0;
		repeat (3) @(negedge clk);
		back_init = 1'b1;
		check_eq("ctrl outputs after init", 32'h0, ctrl_outputs());
		// hit mask has no init
		check_eq("hitmask after init", 32'h0002_d5a3, {14'b0, hitmask});
		foreach (bit_regs[i])
			read_reg($sformatf("ctrl bit %0d after init", i), bit_regs[i], 32'h0);

		reported = 1'b1;
		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== tests/vme_assert.sv ====
module vme_assert (
	input logic clk,
	input logic vme_cycle_end,
	input logic cycle_req,
	input logic bad_addr,
	input logic slot_ok,
	input logic dtack_,
	input logic berr_,
	input logic rd_vme
);
	timeunit 1ns;
	timeprecision 1ps;

	// ******************************
	// acknowledge timing
	// ******************************

	// still high on the seventh edge after the request, low one edge later
	ack_high: assert property (@(posedge clk) disable iff (vme_cycle_end)
		$rose(cycle_req) && !bad_addr |-> ##7 dtack_)
		else $error("dtack_ fell before the seventh edge");
	ack_low: assert property (@(posedge clk) disable iff (vme_cycle_end)
		$rose(cycle_req) && !bad_addr |-> ##8 !dtack_)
		else $error("dtack_ not low after the seventh edge");

	// end of cycle releases everything
	cycle_release: assert property (@(posedge clk)
		$rose(vme_cycle_end) |-> dtack_ && berr_ && !rd_vme)
		else $error("bus outputs not released at cycle end");

	// ******************************
	// address filtering
	// ******************************

	no_answer_off_slot: assert property (@(posedge clk) disable iff (vme_cycle_end)
		!slot_ok |-> dtack_ && berr_)
		else $error("slave answered for another slot");
	berr_excludes_ack: assert property (@(posedge clk) !berr_ |-> dtack_)
		else $error("dtack_ and berr_ low together");

endmodule

bind vme_slave_top vme_assert u_vme_assert (.*);
